// ==== cpu_axi_bridge.f ====
axi_pkg.sv
cpu_pkg.sv
bridge_req_arbiter.sv
bridge_axi_issue.sv
bridge_resp_router.sv
cpu_axi_bridge.sv
tb_axi_mem.sv
tb_cpu_axi_bridge.sv

// ==== tb_cpu_axi_bridge.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_cpu_axi_bridge;

   localparam int n_rows      = 16;
   localparam int cycle_limit = n_rows * 20;

   typedef struct packed {
      cpu_pkg::cpu_op_e kind;
      logic [31:0]      addr;
      logic [31:0]      wdata;
      logic [3:0]       strb;
      logic             cancel;
      logic             par;
   } row_t;

   logic              aclk;
   logic              rst_n;
   logic              inst_req;
   logic [31:0]       inst_addr;
   logic              inst_cancel;
   logic              inst_addr_ok;
   logic              inst_valid;
   cpu_pkg::cpu_rsp_t inst_rsp;
   logic              data_req;
   logic              data_wr;
   logic [31:0]       data_addr;
   logic [31:0]       data_wdata;
   logic [3:0]        data_wstrb;
   logic              data_addr_ok;
   logic              data_ok;
   cpu_pkg::cpu_rsp_t data_rsp;
   axi_pkg::ar_chan_t ar;
   logic              arvalid;
   logic              arready;
   axi_pkg::r_chan_t  r;
   logic              rvalid;
   logic              rready;
   axi_pkg::aw_chan_t aw;
   logic              awvalid;
   logic              awready;
   axi_pkg::w_chan_t  w;
   logic              wvalid;
   logic              wready;
   axi_pkg::b_chan_t  b;
   logic              bvalid;
   logic              bready;

   row_t              tbl [n_rows];
   logic [31:0]       shadow [256];
   logic [n_rows-1:0] accepted;
   int                cycle_cnt;
   int                i;

   cpu_axi_bridge dut (.*);

   tb_axi_mem mem_model (.*);

   initial begin
      aclk = 1'b0;
      forever #4 aclk = ~aclk;
   end

   function automatic logic [31:0] fill_word(input int idx);
      logic [15:0] a;
      a = 16'(idx * 4);
      return {a ^ 16'hc3a5, a};
   endfunction

   task automatic check_value(input string name, input logic [31:0] act,
                              input logic [31:0] exp);
      if (act !== exp) begin
         $display("error: time %0t signal %s actual %h expected %h", $time, name, act, exp);
         $display("TEST RESULT: FAIL");
         $fatal(1, "value mismatch");
      end
   endtask

   // each beat is one word with fixed attributes
   // writes only come from the load/store port
   always @(negedge aclk) begin
      if (arvalid && arready) begin
         check_value("ar.len", ar.len, 4'd0);
         check_value("ar.size", ar.size, 3'b010);
         check_value("ar.burst", ar.burst, 2'b00);
      end
      if (awvalid && awready) begin
         check_value("aw.id", aw.id, 4'd1);
         check_value("aw.len", aw.len, 4'd0);
         check_value("aw.size", aw.size, 3'b010);
         check_value("aw.burst", aw.burst, 2'b00);
      end
      if (wvalid && wready) begin
         check_value("w.id", w.id, 4'd1);
         check_value("w.last", w.last, 1'b1);
      end
   end

   // one access on its own port from request to response
   task automatic run_row(input int idx, input bit solo);
      row_t rw;
      logic exp_err;
      int   wi;
      rw      = tbl[idx];
      exp_err = rw.addr[31];
      wi      = rw.addr[9:2];
      @(posedge aclk);
      #1;
      if (rw.kind == cpu_pkg::op_fetch) begin
         inst_req  = 1'b1;
         inst_addr = rw.addr;
         do @(negedge aclk); while (!inst_addr_ok);
         @(posedge aclk);
         #1;
         inst_req      = 1'b0;
         accepted[idx] = 1'b1;
         if (rw.cancel) begin
            inst_cancel = 1'b1;
            @(posedge aclk);
            #1;
            inst_cancel = 1'b0;
            // dead beat must not reach the core
            do begin
               @(negedge aclk);
               check_value("inst_valid", inst_valid, 1'b0);
            end while (!(rvalid && rready));
         end else begin
            do begin
               @(negedge aclk);
               if (solo) begin
                  check_value("data_ok", data_ok, 1'b0);
               end
            end while (!inst_valid);
            check_value("inst_rsp.err", inst_rsp.err, exp_err);
            if (!exp_err) begin
               check_value("inst_rsp.rdata", inst_rsp.rdata, shadow[wi]);
            end
         end
      end else begin
         data_req   = 1'b1;
         data_wr    = (rw.kind == cpu_pkg::op_store);
         data_addr  = rw.addr;
         data_wdata = rw.wdata;
         data_wstrb = rw.strb;
         do @(negedge aclk); while (!data_addr_ok);
         // data port wins over fetch
         check_value("inst_addr_ok", inst_addr_ok, 1'b0);
         @(posedge aclk);
         #1;
         data_req      = 1'b0;
         accepted[idx] = 1'b1;
         do @(negedge aclk); while (!data_ok);
         check_value("data_rsp.err", data_rsp.err, exp_err);
         if (rw.kind == cpu_pkg::op_store && !exp_err) begin
            for (int k = 0; k < 4; k++) begin
               if (rw.strb[k]) begin
                  shadow[wi][8*k +: 8] = rw.wdata[8*k +: 8];
               end
            end
         end else if (rw.kind == cpu_pkg::op_load && !exp_err) begin
            check_value("data_rsp.rdata", data_rsp.rdata, shadow[wi]);
         end
      end
   endtask

   initial begin
      inst_req    = 1'b0;
      inst_addr   = 32'h0;
      inst_cancel = 1'b0;
      data_req    = 1'b0;
      data_wr     = 1'b0;
      data_addr   = 32'h0;
      data_wdata  = 32'h0;
      data_wstrb  = 4'h0;
      rst_n       = 1'b0;
      accepted    = '0;
      for (int k = 0; k < 256; k++) begin
         shadow[k] = fill_word(k);
      end
      // kind, addr, wdata, strb, cancel, parallel with next
      tbl[0]  = '{cpu_pkg::op_store, 32'h0000_0040, 32'hdead_beef, 4'hf, 1'b0, 1'b0};
      tbl[1]  = '{cpu_pkg::op_load,  32'h0000_0040, 32'h0,         4'hf, 1'b0, 1'b0};
      tbl[2]  = '{cpu_pkg::op_store, 32'h0000_0040, 32'h1234_5678, 4'h5, 1'b0, 1'b0};
      tbl[3]  = '{cpu_pkg::op_load,  32'h0000_0040, 32'h0,         4'hf, 1'b0, 1'b0};
      tbl[4]  = '{cpu_pkg::op_fetch, 32'h0000_0100, 32'h0,         4'h0, 1'b0, 1'b0};
      tbl[5]  = '{cpu_pkg::op_load,  32'h0000_0044, 32'h0,         4'hf, 1'b0, 1'b1};
      tbl[6]  = '{cpu_pkg::op_fetch, 32'h0000_0080, 32'h0,         4'h0, 1'b0, 1'b0};
      tbl[7]  = '{cpu_pkg::op_fetch, 32'h0000_0104, 32'h0,         4'h0, 1'b0, 1'b1};
      tbl[8]  = '{cpu_pkg::op_store, 32'h0000_00c0, 32'hcafe_f00d, 4'hf, 1'b0, 1'b0};
      tbl[9]  = '{cpu_pkg::op_load,  32'h0000_00c0, 32'h0,         4'hf, 1'b0, 1'b0};
      tbl[10] = '{cpu_pkg::op_fetch, 32'h0000_0108, 32'h0,         4'h0, 1'b1, 1'b0};
      tbl[11] = '{cpu_pkg::op_fetch, 32'h0000_010c, 32'h0,         4'h0, 1'b0, 1'b0};
      tbl[12] = '{cpu_pkg::op_load,  32'h8000_0010, 32'h0,         4'hf, 1'b0, 1'b0};
      tbl[13] = '{cpu_pkg::op_fetch, 32'h8000_0020, 32'h0,         4'h0, 1'b0, 1'b0};
      tbl[14] = '{cpu_pkg::op_store, 32'h8000_0030, 32'hffff_ffff, 4'hf, 1'b0, 1'b0};
      tbl[15] = '{cpu_pkg::op_load,  32'h0000_0030, 32'h0,         4'hf, 1'b0, 1'b0};
      repeat (2) @(posedge aclk);
      #1;
      rst_n = 1'b1;
      @(negedge aclk);
      // bus and core side idle out of reset
      check_value("arvalid", arvalid, 1'b0);
      check_value("awvalid", awvalid, 1'b0);
      check_value("wvalid", wvalid, 1'b0);
      check_value("rready", rready, 1'b0);
      check_value("bready", bready, 1'b0);
      check_value("inst_valid", inst_valid, 1'b0);
      check_value("data_ok", data_ok, 1'b0);
      i = 0;
      while (i < n_rows) begin
         if (tbl[i].par) begin
            fork
               run_row(i, 1'b0);
               begin
                  // a store paired with a read goes out once the read is in flight
                  if (tbl[i + 1].kind == cpu_pkg::op_store) begin
                     wait (accepted[i]);
                  end
                  run_row(i + 1, 1'b0);
               end
            join
            i = i + 2;
         end else begin
            run_row(i, 1'b1);
            i = i + 1;
         end
      end
      $display("TEST RESULT: PASS");
      $finish;
   end

   // run length bound
   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < cycle_limit) begin
         @(posedge aclk);
         cycle_cnt = cycle_cnt + 1;
      end
      $display("timeout after %0d cycles, a handshake never completed", cycle_cnt);
      $display("TEST RESULT: FAIL");
      $fatal(1, "timeout");
   end

endmodule

`default_nettype wire

// ==== tb_axi_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_axi_mem (
   input  wire logic              aclk,
   input  wire logic              rst_n,
   input  wire axi_pkg::ar_chan_t ar,
   input  wire logic              arvalid,
   output logic                   arready,
   output axi_pkg::r_chan_t       r,
   output logic                   rvalid,
   input  wire logic              rready,
   input  wire axi_pkg::aw_chan_t aw,
   input  wire logic              awvalid,
   output logic                   awready,
   input  wire axi_pkg::w_chan_t  w,
   input  wire logic              wvalid,
   output logic                   wready,
   output axi_pkg::b_chan_t       b,
   output logic                   bvalid,
   input  wire logic              bready
);

   logic [31:0]       mem [256];
   axi_pkg::aw_chan_t aw_q;
   axi_pkg::w_chan_t  w_q;
   logic              rd_pend;
   logic              aw_got;
   logic              w_got;
   logic [1:0]        rd_cnt;
   logic [1:0]        wr_cnt;
   integer            seed = 32'h6408;

   // 0 to 3 cycles of wait
   function automatic logic [1:0] pick_delay();
      integer v;
      v = $random(seed);
      return v[1:0];
   endfunction

   // fill from the byte address
   initial begin
      for (int i = 0; i < 256; i++) begin
         mem[i] = {16'(i * 4) ^ 16'hc3a5, 16'(i * 4)};
      end
   end

   always @(posedge aclk or negedge rst_n) begin
      if (!rst_n) begin
         arready <= 1'b0;
         rvalid  <= 1'b0;
         r       <= '0;
         rd_pend <= 1'b0;
         rd_cnt  <= 2'd0;
         awready <= 1'b0;
         wready  <= 1'b0;
         bvalid  <= 1'b0;
         b       <= '0;
         aw_got  <= 1'b0;
         w_got   <= 1'b0;
         wr_cnt  <= 2'd0;
      end else begin
         // read side, ready delay then response delay
         if (rvalid) begin
            if (rready) begin
               rvalid <= 1'b0;
               rd_cnt <= pick_delay();
            end
         end else if (rd_pend) begin
            if (rd_cnt == 2'd0) begin
               rvalid  <= 1'b1;
               rd_pend <= 1'b0;
            end else begin
               rd_cnt <= rd_cnt - 2'd1;
            end
         end else if (arvalid && arready) begin
            arready <= 1'b0;
            rd_pend <= 1'b1;
            rd_cnt  <= pick_delay();
            r.id    <= ar.id;
            r.last  <= 1'b1;
            // top half of the map answers slverr
            r.resp  <= ar.addr[31] ? 2'b10 : axi_pkg::resp_okay;
            r.data  <= ar.addr[31] ? 32'h0 : mem[ar.addr[9:2]];
         end else if (arvalid) begin
            if (rd_cnt == 2'd0) begin
               arready <= 1'b1;
            end else begin
               rd_cnt <= rd_cnt - 2'd1;
            end
         end
         // write side, aw and w taken separately
         if (bvalid) begin
            if (bready) begin
               bvalid <= 1'b0;
               wr_cnt <= pick_delay();
            end
         end else if (aw_got && w_got) begin
            if (wr_cnt == 2'd0) begin
               bvalid <= 1'b1;
               aw_got <= 1'b0;
               w_got  <= 1'b0;
               b.id   <= aw_q.id;
               b.resp <= aw_q.addr[31] ? 2'b10 : axi_pkg::resp_okay;
               if (!aw_q.addr[31]) begin
                  for (int k = 0; k < 4; k++) begin
                     if (w_q.strb[k]) begin
                        mem[aw_q.addr[9:2]][8*k +: 8] <= w_q.data[8*k +: 8];
                     end
                  end
               end
            end else begin
               wr_cnt <= wr_cnt - 2'd1;
            end
         end else begin
            if (awvalid && awready) begin
               awready <= 1'b0;
               aw_got  <= 1'b1;
               aw_q    <= aw;
               wr_cnt  <= pick_delay();
            end else if (awvalid && !aw_got) begin
               if (wr_cnt == 2'd0) begin
                  awready <= 1'b1;
               end else begin
                  wr_cnt <= wr_cnt - 2'd1;
               end
            end
            // w ready one cycle after wvalid
            if (wvalid && wready) begin
               wready <= 1'b0;
               w_got  <= 1'b1;
               w_q    <= w;
            end else if (wvalid && !w_got) begin
               wready <= 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== cpu_axi_bridge.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_axi_bridge (
   input  wire logic              aclk,
   input  wire logic              rst_n,
   // fetch port
   input  wire logic              inst_req,
   input  wire logic [31:0]       inst_addr,
   input  wire logic              inst_cancel,
   output logic                   inst_addr_ok,
   output logic                   inst_valid,
   output cpu_pkg::cpu_rsp_t      inst_rsp,
   // load/store port
   input  wire logic              data_req,
   input  wire logic              data_wr,
   input  wire logic [31:0]       data_addr,
   input  wire logic [31:0]       data_wdata,
   input  wire logic [3:0]        data_wstrb,
   output logic                   data_addr_ok,
   output logic                   data_ok,
   output cpu_pkg::cpu_rsp_t      data_rsp,
   // axi
   output axi_pkg::ar_chan_t      ar,
   output logic                   arvalid,
   input  wire logic              arready,
   input  wire axi_pkg::r_chan_t  r,
   input  wire logic              rvalid,
   output logic                   rready,
   output axi_pkg::aw_chan_t      aw,
   output logic                   awvalid,
   input  wire logic              awready,
   output axi_pkg::w_chan_t       w,
   output logic                   wvalid,
   input  wire logic              wready,
   input  wire axi_pkg::b_chan_t  b,
   input  wire logic              bvalid,
   output logic                   bready
);

   logic              issue_valid;
   cpu_pkg::cpu_req_t issue_req;
   logic              rd_busy;
   logic              wr_busy;
   logic              rd_done;
   logic              wr_done;
   logic              rd_is_fetch;

   // grant and slot tracking
   bridge_req_arbiter u_arb (
      .aclk         (aclk),
      .rst_n        (rst_n),
      .inst_req     (inst_req),
      .inst_addr    (inst_addr),
      .data_req     (data_req),
      .data_wr      (data_wr),
      .data_addr    (data_addr),
      .data_wdata   (data_wdata),
      .data_wstrb   (data_wstrb),
      .rd_done      (rd_done),
      .wr_done      (wr_done),
      .inst_addr_ok (inst_addr_ok),
      .data_addr_ok (data_addr_ok),
      .rd_busy      (rd_busy),
      .wr_busy      (wr_busy),
      .issue_valid  (issue_valid),
      .issue_req    (issue_req)
   );

   // ar / aw / w drivers
   bridge_axi_issue u_issue (
      .aclk        (aclk),
      .rst_n       (rst_n),
      .issue_valid (issue_valid),
      .issue_req   (issue_req),
      .ar          (ar),
      .arvalid     (arvalid),
      .arready     (arready),
      .aw          (aw),
      .awvalid     (awvalid),
      .awready     (awready),
      .w           (w),
      .wvalid      (wvalid),
      .wready      (wready),
      .rd_is_fetch (rd_is_fetch)
   );

   // r / b back to the core
   bridge_resp_router u_route (
      .aclk        (aclk),
      .rst_n       (rst_n),
      .r           (r),
      .rvalid      (rvalid),
      .rready      (rready),
      .b           (b),
      .bvalid      (bvalid),
      .bready      (bready),
      .rd_is_fetch (rd_is_fetch),
      .rd_busy     (rd_busy),
      .wr_busy     (wr_busy),
      .inst_cancel (inst_cancel),
      .inst_valid  (inst_valid),
      .inst_rsp    (inst_rsp),
      .data_ok     (data_ok),
      .data_rsp    (data_rsp),
      .rd_done     (rd_done),
      .wr_done     (wr_done)
   );

endmodule

`default_nettype wire

// ==== bridge_resp_router.sv ====
`timescale 1ns/1ns
`default_nettype none

module bridge_resp_router (
   input  wire logic              aclk,
   input  wire logic              rst_n,
   input  wire axi_pkg::r_chan_t  r,
   input  wire logic              rvalid,
   output logic                   rready,
   input  wire axi_pkg::b_chan_t  b,
   input  wire logic              bvalid,
   output logic                   bready,
   input  wire logic              rd_is_fetch,
   input  wire logic              rd_busy,
   input  wire logic              wr_busy,
   input  wire logic              inst_cancel,
   output logic                   inst_valid,
   output cpu_pkg::cpu_rsp_t      inst_rsp,
   output logic                   data_ok,
   output cpu_pkg::cpu_rsp_t      data_rsp,
   output logic                   rd_done,
   output logic                   wr_done
);

   logic r_fire;
   logic b_fire;
   logic r_ifu;
   logic r_err;
   logic b_err;
   logic cancelled;
   logic drop_fetch;

   // ready only while something is outstanding, never back-pressure
   assign rready = rd_busy;
   assign bready = wr_busy;

   assign r_fire = rvalid & rready;
   assign b_fire = bvalid & bready;
   assign r_ifu  = (r.id == axi_pkg::ifu_id);
   assign r_err  = (r.resp != axi_pkg::resp_okay);
   assign b_err  = (b.resp != axi_pkg::resp_okay);

   // cancel may also arrive in the response cycle itself
   assign drop_fetch = cancelled | inst_cancel;

   // fetch port
   assign inst_valid     = r_fire & r_ifu & ~drop_fetch;
   assign inst_rsp.rdata = r.data;
   assign inst_rsp.err   = r_err;

   // load/store port, read data or write ack
   assign data_ok        = (r_fire & ~r_ifu) | b_fire;
   assign data_rsp.rdata = r.data;
   assign data_rsp.err   = (r_fire & ~r_ifu) ? r_err : b_err;

   // slot is freed even for a dropped fetch
   assign rd_done = r_fire;
   assign wr_done = b_fire;

   // remember a cancel until the dead fetch comes back
   always_ff @(posedge aclk or negedge rst_n) begin
      if (!rst_n) begin
         cancelled <= 1'b0;
      end else if (r_fire & r_ifu) begin
         cancelled <= 1'b0;
      end else if (inst_cancel & rd_busy & rd_is_fetch) begin
         cancelled <= 1'b1;
      end
   end

   // returned id agrees with what the issue block sent
   a_rid_match: assert property (@(posedge aclk) disable iff (!rst_n)
      r_fire |-> r.id == (rd_is_fetch ? axi_pkg::ifu_id : axi_pkg::lsu_id));

endmodule

`default_nettype wire

// ==== bridge_axi_issue.sv ====
`timescale 1ns/1ns
`default_nettype none

module bridge_axi_issue (
   input  wire logic               aclk,
   input  wire logic               rst_n,
   input  wire logic               issue_valid,
   input  wire cpu_pkg::cpu_req_t  issue_req,
   output axi_pkg::ar_chan_t       ar,
   output logic                    arvalid,
   input  wire logic               arready,
   output axi_pkg::aw_chan_t       aw,
   output logic                    awvalid,
   input  wire logic               awready,
   output axi_pkg::w_chan_t        w,
   output logic                    wvalid,
   input  wire logic               wready,
   output logic                    rd_is_fetch
);

   logic                         new_ar;
   logic                         new_wr;
   logic                         fetch_req;
   logic [axi_pkg::id_w-1:0]     req_id;
   axi_pkg::ar_chan_t            ar_new;
   axi_pkg::ar_chan_t            ar_q;
   axi_pkg::aw_chan_t            aw_new;
   axi_pkg::aw_chan_t            aw_q;
   axi_pkg::w_chan_t             w_new;
   axi_pkg::w_chan_t             w_q;
   logic                         ar_pend;
   logic                         aw_pend;
   logic                         w_pend;
   logic                         is_fetch_q;

   assign fetch_req = (issue_req.op == cpu_pkg::op_fetch);
   assign new_ar    = issue_valid & (issue_req.op != cpu_pkg::op_store);
   assign new_wr    = issue_valid & (issue_req.op == cpu_pkg::op_store);
   assign req_id    = fetch_req ? axi_pkg::ifu_id : axi_pkg::lsu_id;

   // single beat, one word, no special attributes
   always_comb begin
      ar_new.id    = req_id;
      ar_new.addr  = issue_req.addr;
      ar_new.len   = '0;
      ar_new.size  = axi_pkg::size_word;
      ar_new.burst = axi_pkg::burst_fixed;
      ar_new.lock  = '0;
      ar_new.cache = '0;
      ar_new.prot  = '0;
      aw_new       = axi_pkg::aw_chan_t'(ar_new);
      w_new.id     = req_id;
      w_new.data   = issue_req.wdata;
      w_new.strb   = issue_req.wstrb;
      w_new.last   = 1'b1;
   end

   // valid goes out in the issue cycle, then held from the pend flag
   // issue_valid :  _-_____
   // xready      :  ____-_
   // xvalid      :  _----_
   assign arvalid = new_ar | ar_pend;
   assign awvalid = new_wr | aw_pend;
   assign wvalid  = new_wr | w_pend;

   assign ar = ar_pend ? ar_q : ar_new;
   assign aw = aw_pend ? aw_q : aw_new;
   assign w  = w_pend  ? w_q  : w_new;

   // cover the issue cycle too, a cancel can land there
   assign rd_is_fetch = new_ar ? fetch_req : is_fetch_q;

   always_ff @(posedge aclk or negedge rst_n) begin
      if (!rst_n) begin
         ar_pend    <= 1'b0;
         aw_pend    <= 1'b0;
         w_pend     <= 1'b0;
         is_fetch_q <= 1'b0;
      end else begin
         // aw and w finish on their own
         ar_pend <= arvalid & ~arready;
         aw_pend <= awvalid & ~awready;
         w_pend  <= wvalid & ~wready;
         if (new_ar) begin
            is_fetch_q <= fetch_req;
         end
      end
   end

   // channel copies for back-pressure
   always_ff @(posedge aclk) begin
      if (new_ar) begin
         ar_q <= ar_new;
      end
      if (new_wr) begin
         aw_q <= aw_new;
         w_q  <= w_new;
      end
   end

   // valid held and payload stable until the handshake
   a_ar_hold: assert property (@(posedge aclk) disable iff (!rst_n)
      arvalid && !arready |=> arvalid && $stable(ar));
   a_aw_hold: assert property (@(posedge aclk) disable iff (!rst_n)
      awvalid && !awready |=> awvalid && $stable(aw));
   a_w_hold: assert property (@(posedge aclk) disable iff (!rst_n)
      wvalid && !wready |=> wvalid && $stable(w));

endmodule

`default_nettype wire

// ==== bridge_req_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module bridge_req_arbiter (
   input  wire logic             aclk,
   input  wire logic             rst_n,
   input  wire logic             inst_req,
   input  wire logic [31:0]      inst_addr,
   input  wire logic             data_req,
   input  wire logic             data_wr,
   input  wire logic [31:0]      data_addr,
   input  wire logic [31:0]      data_wdata,
   input  wire logic [3:0]       data_wstrb,
   input  wire logic             rd_done,
   input  wire logic             wr_done,
   output logic                  inst_addr_ok,
   output logic                  data_addr_ok,
   output logic                  rd_busy,
   output logic                  wr_busy,
   output logic                  issue_valid,
   output cpu_pkg::cpu_req_t     issue_req
);

   logic              ld_busy;
   logic              rd_grant;
   logic              wr_grant;
   cpu_pkg::cpu_req_t grant_req;

   // loads and stores share data_ok, so one waits for the other to finish
   // keeps responses in order; fetch and store may overlap freely
   assign data_addr_ok = data_req & (data_wr ? (~wr_busy & ~ld_busy)
                                             : (~rd_busy & ~wr_busy));

   // fetch only when the read slot is free and the data port is not taking this cycle
   assign inst_addr_ok = inst_req & ~rd_busy & ~data_addr_ok;

   assign rd_grant = inst_addr_ok | (data_addr_ok & ~data_wr);
   assign wr_grant = data_addr_ok & data_wr;

   // mux the winning port into one request word
   always_comb begin
      if (data_addr_ok) begin
         grant_req.op    = data_wr ? cpu_pkg::op_store : cpu_pkg::op_load;
         grant_req.addr  = data_addr;
         grant_req.wdata = data_wdata;
         grant_req.wstrb = data_wstrb;
      end else begin
         grant_req.op    = cpu_pkg::op_fetch;
         grant_req.addr  = inst_addr;
         grant_req.wdata = '0;
         grant_req.wstrb = '0;
      end
   end

   // slot flags go busy at the edge after acceptance and clear on done
   always_ff @(posedge aclk or negedge rst_n) begin
      if (!rst_n) begin
         rd_busy     <= 1'b0;
         wr_busy     <= 1'b0;
         ld_busy     <= 1'b0;
         issue_valid <= 1'b0;
      end else begin
         issue_valid <= rd_grant | wr_grant;
         if (rd_grant) begin
            rd_busy <= 1'b1;
         end else if (rd_done) begin
            rd_busy <= 1'b0;
         end
         // load part of the read slot
         if (data_addr_ok & ~data_wr) begin
            ld_busy <= 1'b1;
         end else if (rd_done) begin
            ld_busy <= 1'b0;
         end
         if (wr_grant) begin
            wr_busy <= 1'b1;
         end else if (wr_done) begin
            wr_busy <= 1'b0;
         end
      end
   end

   // payload only
   always_ff @(posedge aclk) begin
      if (rd_grant | wr_grant) begin
         issue_req <= grant_req;
      end
   end

   // a response only ever closes a slot that holds a transfer in flight
   a_rd_done_busy: assert property (@(posedge aclk) disable iff (!rst_n)
      rd_done |-> rd_busy);
   a_wr_done_busy: assert property (@(posedge aclk) disable iff (!rst_n)
      wr_done |-> wr_busy);

endmodule

`default_nettype wire

// ==== cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

   // core word and byte enable widths
   localparam int word_w = 32;
   localparam int strb_w = 4;

   // kind of access taken from a core port
   typedef enum logic [1:0] {
      op_fetch = 2'd0,
      op_load  = 2'd1,
      op_store = 2'd2
   } cpu_op_e;

   // accepted request, handed from arbiter to issue block
   typedef struct packed {
      cpu_op_e           op;
      logic [word_w-1:0] addr;
      logic [word_w-1:0] wdata;
      logic [strb_w-1:0] wstrb;
   } cpu_req_t;

   // response toward a core port
   typedef struct packed {
      logic [word_w-1:0] rdata;
      logic              err;
   } cpu_rsp_t;

endpackage

`default_nettype wire

// ==== axi_pkg.sv ====
`default_nettype none

package axi_pkg;

   // bus widths
   localparam int addr_w  = 32;
   localparam int data_w  = 32;
   localparam int id_w    = 4;
   localparam int strb_w  = data_w / 8;

   // axi3 control field widths
   localparam int len_w   = 4;
   localparam int size_w  = 3;
   localparam int burst_w = 2;
   localparam int lock_w  = 2;
   localparam int cache_w = 4;
   localparam int prot_w  = 3;
   localparam int resp_w  = 2;

   // one id per core port
   localparam logic [id_w-1:0] ifu_id = 4'd0;
   localparam logic [id_w-1:0] lsu_id = 4'd1;

   localparam logic [resp_w-1:0]  resp_okay   = 2'b00;
   // 4 bytes per beat, fixed burst
   localparam logic [size_w-1:0]  size_word   = 3'b010;
   localparam logic [burst_w-1:0] burst_fixed = 2'b00;

   typedef struct packed {
      logic [id_w-1:0]    id;
      logic [addr_w-1:0]  addr;
      logic [len_w-1:0]   len;
      logic [size_w-1:0]  size;
      logic [burst_w-1:0] burst;
      logic [lock_w-1:0]  lock;
      logic [cache_w-1:0] cache;
      logic [prot_w-1:0]  prot;
   } ar_chan_t;

   // same layout as the read address channel
   typedef struct packed {
      logic [id_w-1:0]    id;
      logic [addr_w-1:0]  addr;
      logic [len_w-1:0]   len;
      logic [size_w-1:0]  size;
      logic [burst_w-1:0] burst;
      logic [lock_w-1:0]  lock;
      logic [cache_w-1:0] cache;
      logic [prot_w-1:0]  prot;
   } aw_chan_t;

   typedef struct packed {
      logic [id_w-1:0]   id;
      logic [data_w-1:0] data;
      logic [strb_w-1:0] strb;
      logic              last;
   } w_chan_t;

   typedef struct packed {
      logic [id_w-1:0]   id;
      logic [data_w-1:0] data;
      logic [resp_w-1:0] resp;
      logic              last;
   } r_chan_t;

   typedef struct packed {
      logic [id_w-1:0]   id;
      logic [resp_w-1:0] resp;
   } b_chan_t;

endpackage

`default_nettype wire
